// ==== hw/lcd_text_pkg.sv ====
package lcd_text_pkg;

	// ********************
	// line buffer
	localparam int BUF_DEPTH = 26; // characters on the line
	localparam int ROW_LEN = 13; // characters per lcd row
	localparam int ADDR_W = 5;
	localparam logic [7:0] CHAR_SPACE = 8'h20;
	localparam logic [7:0] SC_DELETE = 8'h66; // set-2 backspace

	// ********************
	// lcd transfer timing, in clk cycles
	localparam int LCD_SLOT_CYCLES = 16;
	localparam int SLOT_W = $clog2(LCD_SLOT_CYCLES);
	localparam int LCD_EN_RISE = 6;
	localparam int LCD_EN_FALL = 12;

	// ********************
	// hd44780 commands
	localparam logic [7:0] CMD_CLEAR = 8'h01;
	localparam logic [7:0] CMD_ENTRY = 8'h06; // increment, no shift
	localparam logic [7:0] CMD_FUNCTION = 8'h38; // 8 bit, 2 lines, 5x7
	localparam logic [7:0] CMD_DISPLAY = 8'h0C; // display on, cursor off
	localparam logic [7:0] CMD_ROW1 = 8'h80;
	localparam logic [7:0] CMD_ROW2 = 8'hC0;

	typedef struct packed {
		logic [7:0] scancode;
		logic shift;
		logic capslock;
		logic valid;
		logic strobe;
	} key_in_t;

	typedef struct packed {
		logic [7:0] ascii;
		logic printable;
		logic del; // delete key
	} key_char_t;

	typedef struct packed {
		logic req;
		logic write;
		logic [ADDR_W-1:0] addr;
		logic [7:0] wdata;
	} buf_req_t;

	typedef struct packed {
		logic en;
		logic rs;
		logic [7:0] data;
	} lcd_bus_t;

endpackage

// ==== hw/key_decoder.sv ====
module key_decoder (
	input lcd_text_pkg::key_in_t key,
	output lcd_text_pkg::key_char_t kchar
);

	logic [7:0] lower; // lower case letter, 0 if not a letter
	logic [15:0] pair; // {plain, shifted}, 0 if not a digit or symbol

	// ********************
	// letters
	always_comb
	begin
		case (key.scancode)
			8'h1C: lower = "a";
			8'h32: lower = "b";
			8'h21: lower = "c";
			8'h23: lower = "d";
			8'h24: lower = "e";
			8'h2B: lower = "f";
			8'h34: lower = "g";
			8'h33: lower = "h";
			8'h43: lower = "i";
			8'h3B: lower = "j";
			8'h42: lower = "k";
			8'h4B: lower = "l";
			8'h3A: lower = "m";
			8'h31: lower = "n";
			8'h44: lower = "o";
			8'h4D: lower = "p";
			8'h15: lower = "q";
			8'h2D: lower = "r";
			8'h1B: lower = "s";
			8'h2C: lower = "t";
			8'h3C: lower = "u";
			8'h2A: lower = "v";
			8'h1D: lower = "w";
			8'h22: lower = "x";
			8'h35: lower = "y";
			8'h1A: lower = "z";
			default: lower = 8'h00;
		endcase
	end

	// ********************
	// digits and punctuation, shift only
	always_comb
	begin
		case (key.scancode)
			8'h45: pair = {"0", ")"};
			8'h16: pair = {"1", "!"};
			8'h1E: pair = {"2", "@"};
			8'h26: pair = {"3", "#"};
			8'h25: pair = {"4", "$"};
			8'h2E: pair = {"5", "%"};
			8'h36: pair = {"6", "^"};
			8'h3D: pair = {"7", "&"};
			8'h3E: pair = {"8", "*"};
			8'h46: pair = {"9", "("};
			8'h4E: pair = {"-", "_"};
			8'h55: pair = {"=", "+"};
			8'h41: pair = {",", "<"};
			8'h49: pair = {".", ">"};
			8'h4A: pair = {"/", "?"};
			8'h4C: pair = {";", ":"};
			default: pair = 16'h0000;
		endcase
	end

	always_comb
	begin
		kchar = '{ascii: lcd_text_pkg::CHAR_SPACE, printable: 1'b0, del: 1'b0};
		if (lower != 8'h00)
		begin
			kchar.ascii = (key.shift ^ key.capslock) ? lower - 8'h20 : lower; // upper case
			kchar.printable = 1'b1;
		end
		else if (pair != 16'h0000)
		begin
			kchar.ascii = key.shift ? pair[7:0] : pair[15:8];
			kchar.printable = 1'b1;
		end
		else if (key.scancode == lcd_text_pkg::SC_DELETE)
			kchar.del = 1'b1;
	end

endmodule

// ==== hw/line_editor.sv ====
module line_editor (
	input logic clk,
	input logic rst_n,
	input logic key_strobe,
	input logic key_valid,
	input lcd_text_pkg::key_char_t kchar,
	output lcd_text_pkg::buf_req_t edit_req,
	input logic edit_gnt
);

	logic strobe_q;
	logic press;
	logic can_add;
	logic can_del;
	logic [lcd_text_pkg::ADDR_W-1:0] cursor; // next free position

	assign press = key_strobe & ~strobe_q & key_valid;
	assign can_add = kchar.printable && (int'(cursor) < lcd_text_pkg::BUF_DEPTH);
	assign can_del = kchar.del && (cursor != '0);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			strobe_q <= 1'b1; // strobe held high at reset is not a press
		else
			strobe_q <= key_strobe;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cursor <= '0;
			edit_req <= '0;
		end
		else if (edit_req.req)
		begin
			if (edit_gnt)
				edit_req.req <= 1'b0; // presses while pending are lost
		end
		else if (press && can_add)
		begin
			edit_req <= '{req: 1'b1, write: 1'b1, addr: cursor, wdata: kchar.ascii};
			cursor <= cursor + 1'b1;
		end
		else if (press && can_del)
		begin
			edit_req <= '{
				req: 1'b1,
				write: 1'b1,
				addr: cursor - 1'b1,
				wdata: lcd_text_pkg::CHAR_SPACE
			};
			cursor <= cursor - 1'b1;
		end
	end

endmodule

// ==== hw/buffer_arbiter.sv ====
module buffer_arbiter (
	input logic clk,
	input logic rst_n,
	input lcd_text_pkg::buf_req_t edit_req,
	input lcd_text_pkg::buf_req_t rd_req,
	output logic edit_gnt,
	output logic rd_gnt,
	output lcd_text_pkg::buf_req_t mem_req
);

	logic last_edit; // editor took the previous grant

	// on contention the side that did not win last time goes first
	assign edit_gnt = edit_req.req & (~rd_req.req | ~last_edit);
	assign rd_gnt = rd_req.req & ~edit_gnt;

	always_comb
	begin
		if (edit_gnt)
			mem_req = edit_req;
		else if (rd_gnt)
			mem_req = rd_req;
		else
			mem_req = '0;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			last_edit <= 1'b0;
		else if (edit_gnt | rd_gnt)
			last_edit <= edit_gnt;
	end

endmodule

// ==== hw/char_buffer.sv ====
module char_buffer (
	input logic clk,
	input logic rst_n,
	input lcd_text_pkg::buf_req_t mem_req,
	output logic [7:0] rdata
);

	logic [7:0] mem [lcd_text_pkg::BUF_DEPTH];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < lcd_text_pkg::BUF_DEPTH; i++)
				mem[i] <= lcd_text_pkg::CHAR_SPACE; // blank line
		end
		else if (mem_req.req && mem_req.write)
			mem[mem_req.addr] <= mem_req.wdata;
	end

	// holds the last read until the next one
	always_ff @(posedge clk)
	begin
		if (mem_req.req && !mem_req.write)
			rdata <= mem[mem_req.addr];
	end

endmodule

// ==== hw/lcd_refresh.sv ====
module lcd_refresh (
	input logic clk,
	input logic rst_n,
	output lcd_text_pkg::buf_req_t rd_req,
	input logic rd_gnt,
	input logic [7:0] rdata,
	output lcd_text_pkg::lcd_bus_t lcd
);

	typedef enum logic [2:0] {
		ST_CLEAR,
		ST_ENTRY,
		ST_FUNCTION,
		ST_DISPLAY,
		ST_ROW1,
		ST_DATA1,
		ST_ROW2,
		ST_DATA2
	} state_t;

	state_t state;
	state_t state_nxt;
	logic [lcd_text_pkg::SLOT_W-1:0] slot_cnt;
	logic slot_end;
	logic [lcd_text_pkg::ADDR_W-1:0] pos; // character being sent
	logic [lcd_text_pkg::ADDR_W-1:0] pos_nxt;
	logic fetch; // prefetch the next character
	logic rs_nxt;
	logic [7:0] data_nxt;

	assign slot_end = int'(slot_cnt) == lcd_text_pkg::LCD_SLOT_CYCLES - 1;

	// ********************
	// slot timer
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			slot_cnt <= lcd_text_pkg::SLOT_W'(lcd_text_pkg::LCD_SLOT_CYCLES - 1);
		else if (slot_end)
			slot_cnt <= '0;
		else
			slot_cnt <= slot_cnt + 1'b1;
	end

	// ********************
	// transfer sequence
	always_comb
	begin
		state_nxt = state;
		pos_nxt = pos;
		fetch = 1'b0;
		rs_nxt = 1'b0;
		data_nxt = rdata; // fetched during the previous slot
		case (state)
			ST_CLEAR:
			begin
				data_nxt = lcd_text_pkg::CMD_CLEAR;
				state_nxt = ST_ENTRY;
			end
			ST_ENTRY:
			begin
				data_nxt = lcd_text_pkg::CMD_ENTRY;
				state_nxt = ST_FUNCTION;
			end
			ST_FUNCTION:
			begin
				data_nxt = lcd_text_pkg::CMD_FUNCTION;
				state_nxt = ST_DISPLAY;
			end
			ST_DISPLAY:
			begin
				data_nxt = lcd_text_pkg::CMD_DISPLAY;
				state_nxt = ST_ROW1;
			end
			ST_ROW1:
			begin
				data_nxt = lcd_text_pkg::CMD_ROW1;
				state_nxt = ST_DATA1;
				fetch = 1'b1;
			end
			ST_DATA1:
			begin
				rs_nxt = 1'b1;
				pos_nxt = pos + 1'b1;
				if (int'(pos) == lcd_text_pkg::ROW_LEN - 1)
					state_nxt = ST_ROW2;
				else
					fetch = 1'b1;
			end
			ST_ROW2:
			begin
				data_nxt = lcd_text_pkg::CMD_ROW2;
				state_nxt = ST_DATA2;
				fetch = 1'b1;
			end
			ST_DATA2:
			begin
				rs_nxt = 1'b1;
				if (int'(pos) == lcd_text_pkg::BUF_DEPTH - 1)
				begin
					pos_nxt = '0;
					state_nxt = ST_ENTRY; // clear only once
				end
				else
				begin
					pos_nxt = pos + 1'b1;
					fetch = 1'b1;
				end
			end
		endcase
	end

	// ********************
	// bus drive
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_CLEAR;
			pos <= '0;
			lcd <= '0;
		end
		else
		begin
			if (slot_end)
			begin
				state <= state_nxt;
				pos <= pos_nxt;
				lcd.rs <= rs_nxt;
				lcd.data <= data_nxt;
			end
			if (int'(slot_cnt) == lcd_text_pkg::LCD_EN_RISE - 1)
				lcd.en <= 1'b1;
			else if (int'(slot_cnt) == lcd_text_pkg::LCD_EN_FALL - 1)
				lcd.en <= 1'b0; // latched by the lcd here
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rd_req <= '0;
		else if (rd_gnt)
			rd_req.req <= 1'b0;
		else if (slot_end && fetch)
			rd_req <= '{req: 1'b1, write: 1'b0, addr: pos_nxt, wdata: 8'h00};
	end

endmodule

// ==== hw/lcd_text_top.sv ====
module lcd_text_top (
	input logic clk,
	input logic rst_n,
	input lcd_text_pkg::key_in_t key,
	output lcd_text_pkg::lcd_bus_t lcd
);

	lcd_text_pkg::key_char_t kchar;
	lcd_text_pkg::buf_req_t edit_req;
	lcd_text_pkg::buf_req_t rd_req;
	lcd_text_pkg::buf_req_t mem_req;
	logic edit_gnt;
	logic rd_gnt;
	logic [7:0] rdata;

	key_decoder u_key_decoder (
		.key(key),
		.kchar(kchar)
	);

	line_editor u_line_editor (
		.clk(clk),
		.rst_n(rst_n),
		.key_strobe(key.strobe),
		.key_valid(key.valid),
		.kchar(kchar),
		.edit_req(edit_req),
		.edit_gnt(edit_gnt)
	);

	// editor writes, refresh reads
	buffer_arbiter u_buffer_arbiter (
		.clk(clk),
		.rst_n(rst_n),
		.edit_req(edit_req),
		.rd_req(rd_req),
		.edit_gnt(edit_gnt),
		.rd_gnt(rd_gnt),
		.mem_req(mem_req)
	);

	char_buffer u_char_buffer (
		.clk(clk),
		.rst_n(rst_n),
		.mem_req(mem_req),
		.rdata(rdata)
	);

	lcd_refresh u_lcd_refresh (
		.clk(clk),
		.rst_n(rst_n),
		.rd_req(rd_req),
		.rd_gnt(rd_gnt),
		.rdata(rdata),
		.lcd(lcd)
	);

endmodule

// ==== tb/lcd_bus_monitor.sv ====
module lcd_bus_monitor (
	input logic rst_n,
	input lcd_text_pkg::lcd_bus_t lcd,
	output int xfer_cnt,
	output logic xfer_rs,
	output logic [7:0] xfer_data,
	output int frame_cnt,
	output logic [lcd_text_pkg::BUF_DEPTH-1:0][7:0] shown
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [lcd_text_pkg::BUF_DEPTH-1:0][7:0] work; // display being rebuilt
	int base; // first position of the current row
	int col;

	initial
	begin
		xfer_cnt = 0;
		xfer_rs = 1'b0;
		xfer_data = 8'h00;
		frame_cnt = 0;
		shown = {lcd_text_pkg::BUF_DEPTH{lcd_text_pkg::CHAR_SPACE}};
		work = shown;
		base = 0;
		col = 0;
	end

	// the lcd takes rs and data on the falling edge of en
	always @(negedge lcd.en)
	begin
		if (rst_n)
		begin
			xfer_rs = lcd.rs;
			xfer_data = lcd.data;
			if (!lcd.rs)
			begin
				case (lcd.data)
					lcd_text_pkg::CMD_CLEAR:
					begin
						work = {lcd_text_pkg::BUF_DEPTH{lcd_text_pkg::CHAR_SPACE}};
						base = 0;
						col = 0;
					end
					lcd_text_pkg::CMD_ROW1:
					begin
						base = 0;
						col = 0;
					end
					lcd_text_pkg::CMD_ROW2:
					begin
						base = lcd_text_pkg::ROW_LEN;
						col = 0;
					end
					default: ; // mode commands leave the address alone
				endcase
			end
			else if (col < lcd_text_pkg::ROW_LEN)
			begin
				work[base + col] = lcd.data;
				col++;
				if (base == lcd_text_pkg::ROW_LEN && col == lcd_text_pkg::ROW_LEN)
				begin
					shown = work; // row 2 complete
					frame_cnt++;
				end
			end
			xfer_cnt++; // last, so the fields above are settled
		end
	end

endmodule

// ==== tb/tb_top.sv ====
module tb_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] SEED = 32'h48509edd;
	localparam int TIMEOUT_CYCLES = 60000; // ~40 presses at two frames each, plus margin
	localparam logic [7:0] SC_UNKNOWN = 8'h76; // escape

	// ********************
	// set-2 us layout
	localparam logic [7:0] LETTER_SC [26] = '{
		8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A,
		8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A
	};
	localparam logic [7:0] DIGIT_SC [10] = '{
		8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
	};
	localparam logic [7:0] DIGIT_SHIFTED [10] = '{")", "!", "@", "#", "$", "%", "^", "&", "*", "("};
	localparam logic [7:0] PUNCT_SC [6] = '{8'h4E, 8'h55, 8'h41, 8'h49, 8'h4A, 8'h4C};
	localparam logic [7:0] PUNCT_PLAIN [6] = '{"-", "=", ",", ".", "/", ";"};
	localparam logic [7:0] PUNCT_SHIFTED [6] = '{"_", "+", "<", ">", "?", ":"};

	logic clk;
	logic rst_n;
	lcd_text_pkg::key_in_t key;
	lcd_text_pkg::lcd_bus_t lcd;
	int mon_xfers;
	logic mon_rs;
	logic [7:0] mon_data;
	int mon_frames;
	logic [lcd_text_pkg::BUF_DEPTH-1:0][7:0] shown;
	logic [7:0] line_q [$]; // reference line
	logic [31:0] rng;
	int cycles = 0;
	int seen_xfers = 0;
	int frame_no = 0;
	int slot_idx = 0;

	lcd_text_top dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.key(key),
		.lcd(lcd)
	);

	lcd_bus_monitor mon0 (
		.rst_n(rst_n),
		.lcd(lcd),
		.xfer_cnt(mon_xfers),
		.xfer_rs(mon_rs),
		.xfer_data(mon_data),
		.frame_cnt(mon_frames),
		.shown(shown)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// {delete, printable, ascii}
	function automatic logic [9:0] ref_key(
		input logic [7:0] sc,
		input logic shift,
		input logic caps
	);
		for (int i = 0; i < 26; i++)
			if (LETTER_SC[i] == sc)
				return {2'b01, ((shift ^ caps) ? 8'h41 : 8'h61) + 8'(i)};
		for (int i = 0; i < 10; i++)
			if (DIGIT_SC[i] == sc)
				return {2'b01, shift ? DIGIT_SHIFTED[i] : 8'h30 + 8'(i)};
		for (int i = 0; i < 6; i++)
			if (PUNCT_SC[i] == sc)
				return {2'b01, shift ? PUNCT_SHIFTED[i] : PUNCT_PLAIN[i]};
		if (sc == lcd_text_pkg::SC_DELETE)
			return {2'b10, lcd_text_pkg::CHAR_SPACE};
		return {2'b00, lcd_text_pkg::CHAR_SPACE};
	endfunction

	// command at each transfer of the first frame, later frames skip index 0
	function automatic logic [7:0] frame_cmd(input int k);
		case (k)
			0: return lcd_text_pkg::CMD_CLEAR;
			1: return lcd_text_pkg::CMD_ENTRY;
			2: return lcd_text_pkg::CMD_FUNCTION;
			3: return lcd_text_pkg::CMD_DISPLAY;
			4: return lcd_text_pkg::CMD_ROW1;
			18: return lcd_text_pkg::CMD_ROW2;
			default: return 8'h00; // data slot
		endcase
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic wait_frames(input int n);
		int target;
		target = mon_frames + n;
		while (mon_frames < target)
			@(negedge clk);
	endtask

	task automatic check_display(input string name);
		logic [7:0] exp;
		for (int i = 0; i < lcd_text_pkg::BUF_DEPTH; i++)
		begin
			exp = (i < line_q.size()) ? line_q[i] : lcd_text_pkg::CHAR_SPACE;
			assert (shown[i] == exp)
			else
				stop_on_error($sformatf("error %s pos %0d expected %h actual %h",
					name, i, exp, shown[i]));
		end
	endtask

	task automatic press_key(
		input logic [7:0] sc,
		input logic shift,
		input logic caps,
		input string name
	);
		logic [9:0] r;
		@(posedge clk);
		#10;
		key.scancode = sc;
		key.shift = shift;
		key.capslock = caps;
		key.valid = 1'b1;
		@(posedge clk);
		#10;
		key.strobe = 1'b1;
		repeat (2) @(posedge clk);
		#10;
		key.strobe = 1'b0;
		r = ref_key(sc, shift, caps);
		if (r[9] && line_q.size() > 0)
			void'(line_q.pop_back());
		else if (r[8] && line_q.size() < lcd_text_pkg::BUF_DEPTH)
			line_q.push_back(r[7:0]);
		wait_frames(2); // first frame may predate the write
		check_display(name);
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
			stop_on_error($sformatf("timeout, tests did not finish within %0d cycles", cycles));
	end

	// ********************
	// transfer order on the lcd bus
	always @(negedge clk)
	begin
		int k;
		logic data_slot;
		if (rst_n && mon_xfers != seen_xfers)
		begin
			seen_xfers = mon_xfers; // transfers are a full slot apart
			k = (frame_no == 0) ? slot_idx : slot_idx + 1;
			data_slot = (k >= 5 && k <= 17) || k >= 19;
			assert (mon_rs == data_slot)
			else
				stop_on_error($sformatf(
					"error frame_sequence frame %0d slot %0d expected rs %0d actual %0d",
					frame_no, slot_idx, data_slot, mon_rs));
			if (!data_slot)
			begin
				assert (mon_data == frame_cmd(k))
				else
					stop_on_error($sformatf(
						"error frame_sequence frame %0d slot %0d expected %h actual %h",
						frame_no, slot_idx, frame_cmd(k), mon_data));
			end
			if (k == 31)
			begin
				frame_no++;
				slot_idx = 0;
			end
			else
				slot_idx++;
		end
	end

	// ********************
	// stimulus
	initial
	begin
		key = '0;
		rst_n = 1'b0;
		rng = SEED;
		repeat (4) @(posedge clk);
		#10;
		assert (lcd == '0)
		else
			stop_on_error($sformatf("error reset_values expected 000 actual %h", lcd));
		rst_n = 1'b1;

		wait_frames(1);
		check_display("init_blank");
		press_key(lcd_text_pkg::SC_DELETE, 1'b0, 1'b0, "delete_empty");

		for (int combo = 0; combo < 4; combo++)
			for (int j = 0; j < 2; j++)
			begin
				rng = xorshift32(rng);
				press_key(LETTER_SC[int'(rng % 32'd26)], 1'(combo), 1'(combo >> 1), "letters");
			end

		press_key(SC_UNKNOWN, 1'b0, 1'b0, "unknown_code"); // line is not empty here

		// digits and symbols alternate, each seen plain and shifted
		for (int j = 0; j < 5; j++)
		begin
			rng = xorshift32(rng);
			if (j % 2 == 0)
				press_key(DIGIT_SC[int'(rng % 32'd10)], 1'(j >> 1), rng[20], "symbols");
			else
				press_key(PUNCT_SC[int'(rng % 32'd6)], 1'(j >> 1), rng[20], "symbols");
		end

		rng = xorshift32(rng);
		press_key(LETTER_SC[int'(rng % 32'd26)], rng[7], rng[13], "row_split"); // 14th char
		press_key(lcd_text_pkg::SC_DELETE, 1'b0, 1'b0, "delete");
		press_key(lcd_text_pkg::SC_DELETE, 1'b1, 1'b0, "delete");

		while (line_q.size() < lcd_text_pkg::BUF_DEPTH)
		begin
			rng = xorshift32(rng);
			press_key(LETTER_SC[int'(rng % 32'd26)], rng[7], rng[13], "full_line");
		end
		rng = xorshift32(rng);
		press_key(LETTER_SC[int'(rng % 32'd26)], rng[7], rng[13], "overflow");

		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== list.f ====
hw/lcd_text_pkg.sv
hw/key_decoder.sv
hw/line_editor.sv
hw/buffer_arbiter.sv
hw/char_buffer.sv
hw/lcd_refresh.sv
hw/lcd_text_top.sv
tb/lcd_bus_monitor.sv
tb/tb_top.sv

// ==== Makefile ====
SIM = obj_dir/Vtb_top

all: run

compile: $(SIM)

$(SIM): list.f hw/*.sv tb/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -f list.f --top-module tb_top -o Vtb_top

run: $(SIM)
	./$(SIM) | tee run.log
	grep -q "RESULT: PASS" run.log

clean:
	rm -rf obj_dir run.log

.PHONY: all compile run clean
